/* tb.f */
verilog/mem_system_pkg.sv
verilog/line_ram.sv
verilog/four_bank_mem.sv
verilog/cache_ctrl.sv
verilog/mem_system.sv
verification/tb_mem_system.sv

/* verification/tb_mem_system.sv */
// Testbench with clock, reset, LFSR stimulus, shadow reference model and checking assertions
`default_nettype none
`timescale 1ns/100ps

module tb_mem_system;

   localparam int timeout_cycles = 200;
   localparam int word_w         = $clog2(mem_system_pkg::WORDS_PER_LINE);

   logic                        clk;
   logic                        reset;
   mem_system_pkg::cache_addr_t addr;
   mem_system_pkg::word_t       data_in;
   logic                        rd;
   logic                        wr;
   mem_system_pkg::word_t       data_out;
   logic                        done;
   logic                        stall;
   logic                        cache_hit;
   logic                        err;

   // Expectations for the current cycle that change 1 ns after each edge
   logic                  in_flight;
   logic                  fresh;
   logic                  err_exp;
   logic                  exp_rd;
   logic                  exp_hit;
   mem_system_pkg::word_t exp_data;

   // Shadow of main memory contents and per-line tag state
   mem_system_pkg::word_t shadow_mem [32768];
   logic                  sh_valid [256];
   logic                  sh_dirty [256];
   logic [4:0]            sh_tag [256];
   logic [15:0]           lfsr_state;
   int                    dirty_evictions;

   mem_system u_dut (
      .clk       (clk),
      .reset     (reset),
      .addr      (addr),
      .data_in   (data_in),
      .rd        (rd),
      .wr        (wr),
      .data_out  (data_out),
      .done      (done),
      .stall     (stall),
      .cache_hit (cache_hit),
      .err       (err)
   );

   initial begin
      clk = 1'b0;
      forever begin
         #2 clk = ~clk;
      end
   end

   task automatic abort_run(input string what);
      $display("%s", what);
      $display("TEST FAILED");
      $fatal(1);
   endtask

   task automatic report_mismatch(input string name, input logic [15:0] got,
                                  input logic [15:0] exp);
      abort_run($sformatf("mismatch %s: got %h, expected %h", name, got, exp));
   endtask

   // Galois form with taps for x^16 + x^14 + x^13 + x^11 + 1
   function automatic logic [15:0] lfsr_step(input logic [15:0] s);
      if (s[0]) begin
         return (s >> 1) ^ 16'hB400;
      end
      return s >> 1;
   endfunction

   // One LFSR step per bit taken
   task automatic draw_bits(input int n, output logic [15:0] v);
      v = '0;
      for (int i = 0; i < n; i++) begin
         v          = {v[14:0], lfsr_state[0]};
         lfsr_state = lfsr_step(lfsr_state);
      end
   endtask

   // Cross one edge and drop the one-cycle strobes
   task automatic tick();
      logic ended;
      ended = done;
      @(posedge clk);
      #1;
      rd      = 1'b0;
      wr      = 1'b0;
      fresh   = 1'b0;
      err_exp = 1'b0;
      // Request retired by the done of the cycle just left
      if (ended) begin
         in_flight = 1'b0;
      end
   endtask

   task automatic send(input logic r, input logic w, input mem_system_pkg::cache_addr_t a,
                       input mem_system_pkg::word_t d, output logic legal);
      int                    waited;
      logic [14:0]           widx;
      logic                  hit_pred;
      mem_system_pkg::word_t rdata_pred;
      waited = 0;
      while (stall !== 1'b0) begin
         tick();
         waited++;
         if (waited > timeout_cycles) begin
            abort_run("stall did not drop within 200 cycles");
         end
      end
      legal      = !(r && w) && !a.offset[0];
      widx       = {a.tag, a.index, a.offset[2:1]};
      hit_pred   = sh_valid[a.index] && (sh_tag[a.index] == a.tag);
      rdata_pred = shadow_mem[widx];
      rd         = r;
      wr         = w;
      addr       = a;
      data_in    = d;
      // Accepting edge
      tick();
      if (legal) begin
         in_flight = 1'b1;
         fresh     = 1'b1;
         exp_rd    = r;
         exp_hit   = hit_pred;
         exp_data  = rdata_pred;
         // Miss on a dirty line forces a write-back
         if (!hit_pred && sh_valid[a.index] && sh_dirty[a.index]) begin
            dirty_evictions++;
         end
         if (w) begin
            shadow_mem[widx] = d;
         end
         // Dirty survives a hit and a miss refills clean
         sh_dirty[a.index] = (hit_pred && sh_dirty[a.index]) || w;
         sh_valid[a.index] = 1'b1;
         sh_tag[a.index]   = a.tag;
      end else begin
         err_exp = 1'b1;
      end
   endtask

   task automatic wait_done();
      int waited;
      waited = 0;
      while (done !== 1'b1) begin
         tick();
         waited++;
         if (waited > timeout_cycles) begin
            abort_run("no done within 200 cycles of an accepted request");
         end
      end
   endtask

   // Quiet outputs with nothing outstanding
   a_idle_done : assert property (@(posedge clk) disable iff (reset) !in_flight |-> !done)
      else report_mismatch("done", 16'($sampled(done)), 16'h0);
   a_idle_stall : assert property (@(posedge clk) disable iff (reset) !in_flight |-> !stall)
      else report_mismatch("stall", 16'($sampled(stall)), 16'h0);
   a_busy_stall : assert property (@(posedge clk) disable iff (reset)
                                   in_flight && !done |-> stall)
      else report_mismatch("stall", 16'($sampled(stall)), 16'h1);
   a_done_stall : assert property (@(posedge clk) disable iff (reset) done |-> !stall)
      else report_mismatch("stall", 16'($sampled(stall)), 16'h0);
   a_err : assert property (@(posedge clk) disable iff (reset) err == err_exp)
      else report_mismatch("err", 16'($sampled(err)), 16'($sampled(err_exp)));
   a_hit_flag : assert property (@(posedge clk) disable iff (reset)
                                 done |-> cache_hit == exp_hit)
      else report_mismatch("cache_hit", 16'($sampled(cache_hit)), 16'($sampled(exp_hit)));
   // Hit finishes in the cycle after acceptance
   a_hit_latency : assert property (@(posedge clk) disable iff (reset) fresh && exp_hit |-> done)
      else report_mismatch("done", 16'($sampled(done)), 16'h1);
   a_read_data : assert property (@(posedge clk) disable iff (reset)
                                  done && exp_rd |-> data_out == exp_data)
      else report_mismatch("data_out", $sampled(data_out), $sampled(exp_data));

   initial begin
      logic [15:0]                 op;
      logic [15:0]                 tsel;
      logic [15:0]                 isel;
      logic [15:0]                 wsel;
      logic [15:0]                 wdat;
      logic                        r;
      logic                        w;
      logic                        odd;
      logic                        legal;
      mem_system_pkg::cache_addr_t a;
      reset           = 1'b1;
      rd              = 1'b0;
      wr              = 1'b0;
      addr            = '0;
      data_in         = '0;
      in_flight       = 1'b0;
      fresh           = 1'b0;
      err_exp         = 1'b0;
      exp_rd          = 1'b0;
      exp_hit         = 1'b0;
      exp_data        = '0;
      dirty_evictions = 0;
      lfsr_state      = 16'd94;
      // Banks start at zero
      for (int i = 0; i < 32768; i++) begin
         shadow_mem[i] = '0;
      end
      for (int i = 0; i < 256; i++) begin
         sh_valid[i] = 1'b0;
         sh_dirty[i] = 1'b0;
         sh_tag[i]   = '0;
      end
      repeat (5) @(posedge clk);
      #1;
      reset = 1'b0;
      repeat (4) tick();
      for (int n = 0; n < 400; n++) begin
         draw_bits(4, op);
         draw_bits(2, tsel);
         draw_bits(2, isel);
         draw_bits(word_w, wsel);
         draw_bits(16, wdat);
         // Op 0 both strobes, 1 odd address, then reads and writes
         r   = (op < 16'd9);
         w   = (op == 16'd0) || (op >= 16'd9);
         odd = (op == 16'd1);
         // Four tags over four indexes
         a.tag    = {1'b0, tsel[1:0], 2'b10};
         a.index  = {isel[1:0], 6'h05};
         a.offset = {wsel[1:0], odd};
         send(r, w, a, wdat, legal);
         if (legal) begin
            wait_done();
         end
      end
      repeat (4) tick();
      if (dirty_evictions == 0) begin
         abort_run("stimulus never evicted a dirty line");
      end else begin
         $display("TEST PASSED");
         $finish;
      end
   end

endmodule

`default_nettype wire

/* verilog/mem_system.sv */
// Top level with cache controller, tag store, data store and banked main memory
`default_nettype none
`timescale 1ns/100ps

module mem_system #(
   parameter int mem_busy_cycles = 4
) (
   input  wire                           clk,
   input  wire                           reset,
   input  wire mem_system_pkg::cache_addr_t addr,
   input  wire mem_system_pkg::word_t    data_in,
   input  wire                           rd,
   input  wire                           wr,
   output mem_system_pkg::word_t         data_out,
   output logic                          done,
   output logic                          stall,
   output logic                          cache_hit,
   output logic                          err
);

   // Tag store port
   logic [7:0]                 tag_index;
   mem_system_pkg::tag_entry_t tag_wdata;
   mem_system_pkg::tag_entry_t tag_rdata;
   logic                       tag_we;

   // Data store port addressed by index and word number
   logic [9:0]                 data_addr;
   mem_system_pkg::word_t      data_wdata;
   mem_system_pkg::word_t      data_rdata;
   logic                       data_we;

   // Main memory port
   mem_system_pkg::mem_req_t   mem_req;
   mem_system_pkg::word_t      mem_rdata;
   logic                       mem_stall;

   cache_ctrl u_ctrl (
      .clk        (clk),
      .reset      (reset),
      .addr       (addr),
      .data_in    (data_in),
      .rd         (rd),
      .wr         (wr),
      .data_out   (data_out),
      .done       (done),
      .stall      (stall),
      .cache_hit  (cache_hit),
      .err        (err),
      .tag_index  (tag_index),
      .tag_wdata  (tag_wdata),
      .tag_we     (tag_we),
      .tag_rdata  (tag_rdata),
      .data_addr  (data_addr),
      .data_wdata (data_wdata),
      .data_we    (data_we),
      .data_rdata (data_rdata),
      .mem_req    (mem_req),
      .mem_rdata  (mem_rdata),
      .mem_stall  (mem_stall)
   );

   // Tags start invalid after reset
   line_ram #(
      .depth          (256),
      .entry_t        (mem_system_pkg::tag_entry_t),
      .clear_on_reset (1'b1)
   ) u_tag_store (
      .clk   (clk),
      .reset (reset),
      .waddr (tag_index),
      .wdata (tag_wdata),
      .we    (tag_we),
      .raddr (tag_index),
      .rdata (tag_rdata)
   );

   line_ram #(
      .depth          (1024),
      .entry_t        (mem_system_pkg::word_t),
      .clear_on_reset (1'b0)
   ) u_data_store (
      .clk   (clk),
      .reset (reset),
      .waddr (data_addr),
      .wdata (data_wdata),
      .we    (data_we),
      .raddr (data_addr),
      .rdata (data_rdata)
   );

   four_bank_mem #(
      .mem_busy_cycles (mem_busy_cycles)
   ) u_mem (
      .clk       (clk),
      .reset     (reset),
      .req       (mem_req),
      .mem_rdata (mem_rdata),
      .mem_stall (mem_stall)
   );

endmodule

`default_nettype wire

/* verilog/cache_ctrl.sv */
// Cache controller FSM for tag lookup, dirty write-back, pipelined line fill and completion
`default_nettype none
`timescale 1ns/100ps

module cache_ctrl (
   input  wire                           clk,
   input  wire                           reset,
   // Processor side
   input  wire mem_system_pkg::cache_addr_t addr,
   input  wire mem_system_pkg::word_t    data_in,
   input  wire                           rd,
   input  wire                           wr,
   output mem_system_pkg::word_t         data_out,
   output logic                          done,
   output logic                          stall,
   output logic                          cache_hit,
   output logic                          err,
   // Tag store
   output logic [7:0]                    tag_index,
   output mem_system_pkg::tag_entry_t    tag_wdata,
   output logic                          tag_we,
   input  wire mem_system_pkg::tag_entry_t tag_rdata,
   // Data store
   output logic [9:0]                    data_addr,
   output mem_system_pkg::word_t         data_wdata,
   output logic                          data_we,
   input  wire mem_system_pkg::word_t    data_rdata,
   // Main memory
   output mem_system_pkg::mem_req_t      mem_req,
   input  wire mem_system_pkg::word_t    mem_rdata,
   input  wire                           mem_stall
);

   localparam int lat    = mem_system_pkg::MEM_READ_LATENCY;
   localparam int word_w = $clog2(mem_system_pkg::WORDS_PER_LINE);
   localparam logic [word_w-1:0] last_word = word_w'(mem_system_pkg::WORDS_PER_LINE - 1);

   typedef enum logic [2:0] {
      s_idle,
      s_compare,
      s_write_back,
      s_fill,
      s_finish
   } state_t;

   state_t                      state;
   state_t                      state_nxt;
   mem_system_pkg::cache_addr_t req_addr;
   mem_system_pkg::word_t       req_data;
   logic                        req_wr;
   logic [word_w-1:0]           issue_cnt;
   logic [word_w-1:0]           ret_cnt;
   logic                        fill_issued;
   logic [lat-1:0]              rd_inflight;
   logic                        err_q;
   logic                        hit;
   logic                        accept;
   logic                        bad_req;
   logic                        mem_accept;
   logic                        ret_valid;

   // Tag match on the registered request
   assign hit = tag_rdata.valid && (tag_rdata.tag == req_addr.tag);

   assign done      = ((state == s_compare) && hit) || (state == s_finish);
   assign cache_hit = (state == s_compare) && hit;
   // New request welcome in idle and in the done cycle
   assign stall     = !((state == s_idle) || done);
   assign err       = err_q;
   assign data_out  = data_rdata;

   assign accept  = !stall && (rd || wr);
   // Both strobes or an odd byte address
   assign bad_req = (rd && wr) || addr.offset[0];

   assign mem_accept = (mem_req.rd || mem_req.wr) && !mem_stall;
   // Oldest in-flight read lands on mem_rdata this cycle
   assign ret_valid  = rd_inflight[lat-1];

   // Request capture
   always_ff @(posedge clk) begin
      if (accept && !bad_req) begin
         req_addr <= addr;
         req_data <= data_in;
         req_wr   <= wr;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         state       <= s_idle;
         issue_cnt   <= '0;
         ret_cnt     <= '0;
         fill_issued <= 1'b0;
         rd_inflight <= '0;
         err_q       <= 1'b0;
      end else begin
         state       <= state_nxt;
         err_q       <= accept && bad_req;
         rd_inflight <= (rd_inflight << 1) | lat'(mem_req.rd && !mem_stall);
         if (state == s_compare) begin
            issue_cnt   <= '0;
            ret_cnt     <= '0;
            fill_issued <= 1'b0;
         end
         // Wraps to word 0 after write-back so the fill starts at word 0
         if (mem_accept) begin
            issue_cnt <= issue_cnt + 1'b1;
            if ((state == s_fill) && (issue_cnt == last_word)) begin
               fill_issued <= 1'b1;
            end
         end
         if (ret_valid) begin
            ret_cnt <= ret_cnt + 1'b1;
         end
      end
   end

   // Next state
   always_comb begin
      state_nxt = state;
      case (state)
         s_idle: state_nxt = s_idle;
         s_compare: begin
            if (hit) begin
               state_nxt = s_idle;
            end else if (tag_rdata.valid && tag_rdata.dirty) begin
               state_nxt = s_write_back;
            end else begin
               state_nxt = s_fill;
            end
         end
         s_write_back: begin
            if (mem_accept && (issue_cnt == last_word)) begin
               state_nxt = s_fill;
            end
         end
         s_fill: begin
            // Last fill word arriving
            if (ret_valid && (ret_cnt == last_word)) begin
               state_nxt = s_finish;
            end
         end
         s_finish: state_nxt = s_idle;
         default:  state_nxt = s_idle;
      endcase
      // Back-to-back request out of a done cycle
      if (accept && !bad_req) begin
         state_nxt = s_compare;
      end
   end

   // Store and memory controls
   always_comb begin
      tag_index  = req_addr.index;
      tag_wdata  = '{valid: 1'b1, dirty: req_wr, tag: req_addr.tag};
      tag_we     = 1'b0;
      data_addr  = {req_addr.index, req_addr.offset[2:1]};
      data_wdata = req_data;
      data_we    = 1'b0;
      mem_req    = '0;
      case (state)
         s_compare: begin
            // Write hit updates the word and marks the line dirty
            if (hit && req_wr) begin
               tag_we  = 1'b1;
               data_we = 1'b1;
            end
         end
         s_write_back: begin
            // Old line goes out under its stored tag
            data_addr    = {req_addr.index, issue_cnt};
            mem_req.wr   = 1'b1;
            mem_req.addr = {tag_rdata.tag, req_addr.index, issue_cnt, 1'b0};
            mem_req.data = data_rdata;
         end
         s_fill: begin
            data_addr    = {req_addr.index, ret_cnt};
            data_wdata   = mem_rdata;
            data_we      = ret_valid;
            mem_req.rd   = !fill_issued;
            mem_req.addr = {req_addr.tag, req_addr.index, issue_cnt, 1'b0};
         end
         s_finish: begin
            // Write the new tag and merge the write word over the filled line
            tag_we  = 1'b1;
            data_we = req_wr;
         end
         default: begin
         end
      endcase
   end

   a_done_err_excl : assert property (@(posedge clk) disable iff (reset) !(done && err))
      else $error("done and err in the same cycle");

   // Every fill read has landed by the time the request completes
   a_no_read_at_done : assert property (@(posedge clk) disable iff (reset)
                                        done |-> (rd_inflight == '0))
      else $error("memory read still in flight at done");

endmodule

`default_nettype wire

/* verilog/four_bank_mem.sv */
// Four word-interleaved memory banks with busy countdowns, bank stall and fixed read latency
`default_nettype none
`timescale 1ns/100ps

module four_bank_mem #(
   parameter int mem_busy_cycles = 4
) (
   input  wire                        clk,
   input  wire                        reset,
   input  wire mem_system_pkg::mem_req_t req,
   output mem_system_pkg::word_t      mem_rdata,
   output logic                       mem_stall
);

   localparam int lat    = mem_system_pkg::MEM_READ_LATENCY;
   localparam int busy_w = $clog2(mem_busy_cycles + 1);
   localparam int rows   = 8192;

   // Bank must outlast the read pipeline
   if (mem_busy_cycles < lat) begin : g_bad_busy
      $error("mem_busy_cycles below MEM_READ_LATENCY");
   end

   // Bank storage cleared at time zero
   mem_system_pkg::word_t banks [4][rows] = '{default: '{default: '0}};
   mem_system_pkg::word_t rd_pipe [lat];
   logic [busy_w-1:0]     busy_cnt [4];
   logic [1:0]            bank_sel;
   logic [12:0]           row_sel;
   logic                  access;

   // Word address bits 2:1 pick the bank and the rest the row
   assign bank_sel = req.addr[2:1];
   assign row_sel  = req.addr[15:3];

   // Addressed bank still counting down
   assign mem_stall = (busy_cnt[bank_sel] != '0);
   assign access    = (req.rd || req.wr) && !mem_stall;

   assign mem_rdata = rd_pipe[lat-1];

   // Busy countdown per bank
   always_ff @(posedge clk) begin
      if (reset) begin
         for (int b = 0; b < 4; b++) begin
            busy_cnt[b] <= '0;
         end
      end else begin
         for (int b = 0; b < 4; b++) begin
            if (access && (bank_sel == 2'(b))) begin
               busy_cnt[b] <= busy_w'(mem_busy_cycles);
            end else if (busy_cnt[b] != '0) begin
               busy_cnt[b] <= busy_cnt[b] - 1'b1;
            end
         end
      end
   end

   // Bank write and read-data pipeline
   always_ff @(posedge clk) begin
      if (access && req.wr) begin
         banks[bank_sel][row_sel] <= req.data;
      end
      // Stage 0 catches the word at the accepting edge
      if (access && req.rd) begin
         rd_pipe[0] <= banks[bank_sel][row_sel];
      end
      for (int s = 1; s < lat; s++) begin
         rd_pipe[s] <= rd_pipe[s-1];
      end
   end

   a_rd_wr_excl : assert property (@(posedge clk) disable iff (reset) !(req.rd && req.wr))
      else $error("memory read and write in the same cycle");

   a_idle_in_reset : assert property (@(posedge clk) reset |-> !(req.rd || req.wr))
      else $error("memory request during reset");

endmodule

`default_nettype wire

/* verilog/line_ram.sv */
// Storage array with one write port, asynchronous read and optional clear on reset
`default_nettype none
`timescale 1ns/100ps

module line_ram #(
   parameter int  depth          = 256,
   parameter type entry_t        = logic [15:0],
   parameter bit  clear_on_reset = 1'b0
) (
   input  wire                       clk,
   input  wire                       reset,
   input  wire [$clog2(depth)-1:0]   waddr,
   input  wire entry_t               wdata,
   input  wire                       we,
   input  wire [$clog2(depth)-1:0]   raddr,
   output entry_t                    rdata
);

   entry_t mem [depth];

   always_ff @(posedge clk) begin
      if (reset && clear_on_reset) begin
         // All entries back to zero so every tag reads invalid
         for (int i = 0; i < depth; i++) begin
            mem[i] <= '0;
         end
      end else if (we) begin
         mem[waddr] <= wdata;
      end
   end

   // Read is combinational from the address
   assign rdata = mem[raddr];

   // Controller must stay quiet while reset holds
   a_no_write_in_reset : assert property (@(posedge clk) reset |-> !we)
      else $error("line_ram written during reset");

endmodule

`default_nettype wire

/* verilog/mem_system_pkg.sv */
// Shared word, address, tag entry and memory request types and the subsystem constants
`default_nettype none

package mem_system_pkg;

   // One data word
   typedef logic [15:0] word_t;

   // Processor byte address split for the direct-mapped cache
   typedef struct packed {
      logic [4:0] tag;
      logic [7:0] index;
      // Bits 2:1 pick the word and bit 0 must stay zero
      logic [2:0] offset;
   } cache_addr_t;

   // Tag store entry, one per line
   typedef struct packed {
      logic       valid;
      logic       dirty;
      logic [4:0] tag;
   } tag_entry_t;

   // Request to the banked main memory
   typedef struct packed {
      logic       rd;
      logic       wr;
      // Word-aligned byte address
      logic [15:0] addr;
      word_t      data;
   } mem_req_t;

   // Cycles from an accepted memory read to its data on mem_rdata
   localparam int MEM_READ_LATENCY = 2;

   // Words in one cache line
   localparam int WORDS_PER_LINE = 4;

endpackage

`default_nettype wire
